// ==== Bender.yml ====
package:
  name: lsu_mem_path

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_agu.sv
      - source/ex_mem_stage.sv
      - source/load_align.sv
      - source/lsu_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - tests/lsu_tb.sv

# simulation top: lsu_tb, design top: lsu_top

// ==== build.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_agu.sv
source/ex_mem_stage.sv
source/load_align.sv
source/lsu_top.sv
tests/lsu_tb.sv

// ==== source/ex_mem_stage.sv ====
`include "lsu_defs.svh"

module ex_mem_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  lsu_pkg::mem_cmd_t   cmd,
  output logic [31:0]         dsram_addr,
  output logic                dsram_cs,
  output logic                dsram_we,
  output logic [3:0]          dsram_ben,
  output logic [31:0]         dsram_wdata,
  output lsu_pkg::exc_t       exc,
  output lsu_pkg::load_tag_t  tag
);

  import lsu_pkg::*;

  logic     vld_q;
  mem_cmd_t cmd_q;
  logic     access;
  logic     trap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= cmd.valid;
    end
  end

  always_ff @(posedge clk) begin
    cmd_q <= cmd;
  end

  assign trap   = vld_q & cmd_q.misaligned;
  assign access = vld_q & ~cmd_q.misaligned;

  // sram port driven with the word aligned address
  assign dsram_addr  = {cmd_q.addr.word.idx, 2'b00};
  assign dsram_cs    = access;
  assign dsram_we    = access & cmd_q.store;
  assign dsram_ben   = access ? cmd_q.ben : 4'b0000;
  assign dsram_wdata = cmd_q.data;

  // misaligned access reported instead of touching the sram
  assign exc = '{
    valid: trap,
    cause: cmd_q.store ? `LSU_CAUSE_STORE_MISALIGN : `LSU_CAUSE_LOAD_MISALIGN,
    tval:  cmd_q.addr.byte_addr
  };

  // wb_en already excludes misaligned and x0 loads
  assign tag = '{
    valid:  vld_q & cmd_q.wb_en,
    op:     cmd_q.op,
    offset: cmd_q.addr.word.offset,
    rd:     cmd_q.rd
  };

  // the sram only sees accesses aligned to their width and never a trap
  a_cs_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    dsram_cs |-> !(exc.valid ||
                   (cmd_q.op[0] && cmd_q.addr.word.offset[0]) ||
                   (cmd_q.op[1] && cmd_q.addr.word.offset != 2'b00))
  );

  // store with empty lanes would be a lost write
  a_we_has_ben: assert property (
    @(posedge clk) disable iff (!rst_n)
    dsram_we |-> (dsram_ben != 4'b0000)
  );

endmodule

// ==== source/load_align.sv ====
`include "lsu_defs.svh"

module load_align (
  input  logic               clk,
  input  logic               rst_n,
  input  lsu_pkg::load_tag_t tag,
  input  logic [31:0]        dsram_rdata,
  output lsu_pkg::wb_t       wb
);

  import lsu_pkg::*;

  logic                  tag_vld_q;
  load_tag_t             tag_q;
  logic [`LSU_XLEN-1:0]  lane;
  logic [`LSU_XLEN-1:0]  ld_data;
  logic                  wb_vld_q;
  logic [`LSU_REG_W-1:0] wb_rd_q;
  logic [`LSU_XLEN-1:0]  wb_data_q;

  // tag waits here while the sram read is outstanding
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_vld_q <= 1'b0;
    end else begin
      tag_vld_q <= tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= tag;
  end

  // addressed byte or halfword down to bit 0
  assign lane = dsram_rdata >> {tag_q.offset, 3'b000};

  always_comb begin
    case (tag_q.op)
      OP_LB:   ld_data = {{24{lane[7]}}, lane[7:0]};
      OP_LH:   ld_data = {{16{lane[15]}}, lane[15:0]};
      OP_LBU:  ld_data = {24'd0, lane[7:0]};
      OP_LHU:  ld_data = {16'd0, lane[15:0]};
      default: ld_data = dsram_rdata;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_vld_q <= 1'b0;
    end else begin
      wb_vld_q <= tag_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= tag_q.rd;
    wb_data_q <= ld_data;
  end

  assign wb = '{
    valid: wb_vld_q,
    rd:    wb_rd_q,
    data:  wb_data_q
  };

  // x0 filtering happens back in address generation
  a_wb_not_x0: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb.valid |-> (wb.rd != '0)
  );

endmodule

// ==== source/lsu_agu.sv ====
`include "lsu_defs.svh"

module lsu_agu (
  input  lsu_pkg::mem_req_t req,
  output lsu_pkg::mem_cmd_t cmd
);

  import lsu_pkg::*;

  lsu_addr_u              addr;
  logic                   misaligned;
  logic [`LSU_XLEN/8-1:0] ben_base;
  logic [`LSU_XLEN/8-1:0] ben;
  logic [`LSU_XLEN-1:0]   lane_data;
  logic                   wb_en;

  // effective address
  assign addr.byte_addr = req.base + req.offset;

  // access width from funct3 low bits
  always_comb begin
    case (req.op[1:0])
      2'b00: begin
        misaligned = 1'b0;
        ben_base   = 4'b0001;
      end
      2'b01: begin
        misaligned = addr.word.offset[0];
        ben_base   = 4'b0011;
      end
      default: begin
        misaligned = |addr.word.offset;
        ben_base   = 4'b1111;
      end
    endcase
  end

  // move enables and store data into their byte lanes
  assign ben       = ben_base << addr.word.offset;
  assign lane_data = req.wdata << {addr.word.offset, 3'b000};

  // no writeback for stores, traps or x0
  assign wb_en = req.valid & ~req.store & ~misaligned & (req.rd != '0);

  assign cmd = '{
    valid:      req.valid,
    store:      req.store,
    op:         req.op,
    addr:       addr,
    ben:        ben,
    data:       lane_data,
    rd:         req.rd,
    wb_en:      wb_en,
    misaligned: req.valid & misaligned
  };

endmodule

// ==== source/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width
`define LSU_XLEN 32

// register index width
`define LSU_REG_W 5

// mcause codes for misaligned accesses
`define LSU_CAUSE_LOAD_MISALIGN  5'd4
`define LSU_CAUSE_STORE_MISALIGN 5'd6

`endif

// ==== source/lsu_pkg.sv ====
`include "lsu_defs.svh"

package lsu_pkg;

  // funct3 encoding, stores reuse the lb/lh/lw codes
  typedef enum logic [2:0] {
    OP_LB  = 3'b000,
    OP_LH  = 3'b001,
    OP_LW  = 3'b010,
    OP_LBU = 3'b100,
    OP_LHU = 3'b101
  } mem_op_e;

  // one address word seen flat or as word index plus byte offset
  typedef union packed {
    logic [`LSU_XLEN-1:0] byte_addr;
    struct packed {
      logic [`LSU_XLEN-3:0] idx;
      logic [1:0]           offset;
    } word;
  } lsu_addr_u;

  typedef struct packed {
    logic                  valid;
    logic                  store;
    mem_op_e               op;
    logic [`LSU_XLEN-1:0]  base;
    logic [`LSU_XLEN-1:0]  offset;
    logic [`LSU_XLEN-1:0]  wdata;
    logic [`LSU_REG_W-1:0] rd;
  } mem_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   store;
    mem_op_e                op;
    lsu_addr_u              addr;
    logic [`LSU_XLEN/8-1:0] ben;
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_REG_W-1:0]  rd;
    logic                   wb_en;
    logic                   misaligned;
  } mem_cmd_t;

  // load in flight across the sram read
  typedef struct packed {
    logic                  valid;
    mem_op_e               op;
    logic [1:0]            offset;
    logic [`LSU_REG_W-1:0] rd;
  } load_tag_t;

  typedef struct packed {
    logic                 valid;
    logic [4:0]           cause;
    logic [`LSU_XLEN-1:0] tval;
  } exc_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_REG_W-1:0] rd;
    logic [`LSU_XLEN-1:0]  data;
  } wb_t;

endpackage

// ==== source/lsu_top.sv ====
module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::mem_req_t req,
  input  logic [31:0]       dsram_rdata,
  output logic [31:0]       dsram_addr,
  output logic              dsram_cs,
  output logic              dsram_we,
  output logic [3:0]        dsram_ben,
  output logic [31:0]       dsram_wdata,
  output lsu_pkg::exc_t     exc,
  output lsu_pkg::wb_t      wb
);

  import lsu_pkg::*;

  mem_cmd_t  cmd;
  load_tag_t tag;

  // address, alignment and lanes
  lsu_agu lsu_agu_u (
    .req (req),
    .cmd (cmd)
  );

  // ex/mem register and sram request
  ex_mem_stage ex_mem_stage_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .dsram_addr  (dsram_addr),
    .dsram_cs    (dsram_cs),
    .dsram_we    (dsram_we),
    .dsram_ben   (dsram_ben),
    .dsram_wdata (dsram_wdata),
    .exc         (exc),
    .tag         (tag)
  );

  // read data extraction and writeback
  load_align load_align_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag         (tag),
    .dsram_rdata (dsram_rdata),
    .wb          (wb)
  );

endmodule

// ==== tests/lsu_tb.sv ====
`include "lsu_defs.svh"

module lsu_tb;

  import lsu_pkg::*;

  typedef enum logic [1:0] {
    EXP_NONE,
    EXP_WB,
    EXP_EXC,
    EXP_STORE
  } exp_kind_e;

  // one table row with the request and its expected result
  typedef struct packed {
    mem_req_t    req;
    exp_kind_e   kind;
    logic [3:0]  ben;
    logic [31:0] val;
    logic [4:0]  cause;
  } entry_t;

  logic        clk;
  logic        rst_n;
  mem_req_t    req;
  logic [31:0] dsram_rdata;
  logic [31:0] dsram_addr;
  logic        dsram_cs;
  logic        dsram_we;
  logic [3:0]  dsram_ben;
  logic [31:0] dsram_wdata;
  exc_t        exc;
  wb_t         wb;

  entry_t      tbl[$];
  int          tbl_len;
  int          cur_idx;
  int          cyc;
  int          err_cnt;
  int          acc_due[$];
  int          acc_idx[$];
  int          wb_due[$];
  wb_t         wb_exp[$];
  logic [31:0] sram [0:63];

  lsu_top lsu_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .dsram_rdata (dsram_rdata),
    .dsram_addr  (dsram_addr),
    .dsram_cs    (dsram_cs),
    .dsram_we    (dsram_we),
    .dsram_ben   (dsram_ben),
    .dsram_wdata (dsram_wdata),
    .exc         (exc),
    .wb          (wb)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // synchronous sram with byte enabled writes and registered read data
  initial begin
    dsram_rdata = 32'h0;
    for (int i = 0; i < 64; i++) begin
      sram[i] = 32'h9e3779b9 * (i + 1);
    end
  end

  always @(posedge clk) begin
    if (dsram_cs && dsram_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dsram_ben[b]) begin
          sram[dsram_addr[7:2]][8*b +: 8] <= dsram_wdata[8*b +: 8];
        end
      end
    end
    if (dsram_cs && !dsram_we) begin
      dsram_rdata <= sram[dsram_addr[7:2]];
    end
  end

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_wb(input wb_t got, input wb_t exp);
    if (got !== exp) begin
      report_fail($sformatf("Error at %0t: wb valid=%0b rd=%0d data=%h, expected rd=%0d data=%h",
                            $time, got.valid, got.rd, got.data, exp.rd, exp.data));
    end
  endtask

  task automatic check_exc(input exc_t got, input exc_t exp);
    if (got !== exp) begin
      report_fail($sformatf(
        "Error at %0t: exc valid=%0b cause=%0d tval=%h, expected cause=%0d tval=%h",
        $time, got.valid, got.cause, got.tval, exp.cause, exp.tval));
    end
  endtask

  task automatic check_store(input logic [3:0] ben, input logic [31:0] wdata,
                             input logic [3:0] exp_ben, input logic [31:0] exp_wdata);
    if (ben !== exp_ben || wdata !== exp_wdata) begin
      report_fail($sformatf("Error at %0t: store ben=%b wdata=%h, expected ben=%b wdata=%h",
                            $time, ben, wdata, exp_ben, exp_wdata));
    end
  endtask

  task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("Error at %0t: sram addr=%h, expected %h", $time, got, exp));
    end
  endtask

  task automatic add_load(input mem_op_e op, input logic [31:0] base, input logic [31:0] off,
                          input logic [4:0] rd, input logic [31:0] data);
    entry_t e;
    e = '0;
    e.req.valid  = 1'b1;
    e.req.op     = op;
    e.req.base   = base;
    e.req.offset = off;
    e.req.rd     = rd;
    // x0 loads still read the sram but never write back
    e.kind = (rd != 5'd0) ? EXP_WB : EXP_NONE;
    e.val  = data;
    tbl.push_back(e);
  endtask

  task automatic add_store(input mem_op_e op, input logic [31:0] base, input logic [31:0] off,
                           input logic [31:0] wdata, input logic [3:0] ben,
                           input logic [31:0] lane);
    entry_t e;
    e = '0;
    e.req.valid  = 1'b1;
    e.req.store  = 1'b1;
    e.req.op     = op;
    e.req.base   = base;
    e.req.offset = off;
    e.req.wdata  = wdata;
    e.kind = EXP_STORE;
    e.ben  = ben;
    e.val  = lane;
    tbl.push_back(e);
  endtask

  task automatic add_trap(input logic store, input mem_op_e op, input logic [31:0] base,
                          input logic [31:0] off, input logic [4:0] rd, input logic [4:0] cause);
    entry_t e;
    e = '0;
    e.req.valid  = 1'b1;
    e.req.store  = store;
    e.req.op     = op;
    e.req.base   = base;
    e.req.offset = off;
    e.req.wdata  = 32'hffffffff;
    e.req.rd     = rd;
    e.kind  = EXP_EXC;
    e.cause = cause;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // word store then load back to back
    add_store(OP_LW, 32'h30, 32'h10, 32'h12345678, 4'b1111, 32'h12345678);
    add_load(OP_LW, 32'h40, 32'h0, 5'd5, 32'h12345678);
    // byte lanes of word 0x50
    add_store(OP_LB, 32'h50, 32'h0, 32'hdeadbea1, 4'b0001, 32'hdeadbea1);
    add_store(OP_LB, 32'h50, 32'h1, 32'hffffffb2, 4'b0010, 32'hffffb200);
    add_store(OP_LB, 32'h50, 32'h2, 32'h000000c3, 4'b0100, 32'h00c30000);
    add_store(OP_LB, 32'h50, 32'h3, 32'h123456d4, 4'b1000, 32'hd4000000);
    add_load(OP_LW, 32'h50, 32'h0, 5'd9, 32'hd4c3b2a1);
    // halfword lanes of word 0x60 with one negative offset
    add_store(OP_LH, 32'h64, 32'hfffffffc, 32'h0000beef, 4'b0011, 32'h0000beef);
    add_store(OP_LH, 32'h60, 32'h2, 32'h7777cafe, 4'b1100, 32'hcafe0000);
    add_load(OP_LW, 32'h60, 32'h0, 5'd10, 32'hcafebeef);
    // sign and zero extension
    add_store(OP_LW, 32'h70, 32'h0, 32'h80ff7f01, 4'b1111, 32'h80ff7f01);
    add_load(OP_LW, 32'h6f, 32'h1, 5'd11, 32'h80ff7f01);
    add_load(OP_LB, 32'h70, 32'h0, 5'd12, 32'h00000001);
    add_load(OP_LB, 32'h70, 32'h1, 5'd13, 32'h0000007f);
    add_load(OP_LB, 32'h70, 32'h2, 5'd14, 32'hffffffff);
    add_load(OP_LB, 32'h70, 32'h3, 5'd15, 32'hffffff80);
    add_load(OP_LBU, 32'h70, 32'h2, 5'd16, 32'h000000ff);
    add_load(OP_LBU, 32'h70, 32'h3, 5'd17, 32'h00000080);
    add_load(OP_LH, 32'h70, 32'h0, 5'd18, 32'h00007f01);
    add_load(OP_LH, 32'h70, 32'h2, 5'd19, 32'hffff80ff);
    add_load(OP_LHU, 32'h70, 32'h0, 5'd20, 32'h00007f01);
    add_load(OP_LHU, 32'h70, 32'h2, 5'd21, 32'h000080ff);
    // misaligned accesses trap and leave memory alone
    add_trap(1'b0, OP_LH, 32'h70, 32'h1, 5'd6, `LSU_CAUSE_LOAD_MISALIGN);
    add_trap(1'b0, OP_LW, 32'h70, 32'h2, 5'd7, `LSU_CAUSE_LOAD_MISALIGN);
    add_trap(1'b1, OP_LH, 32'h40, 32'h3, 5'd0, `LSU_CAUSE_STORE_MISALIGN);
    add_trap(1'b1, OP_LW, 32'h41, 32'h0, 5'd0, `LSU_CAUSE_STORE_MISALIGN);
    add_load(OP_LW, 32'h40, 32'h0, 5'd8, 32'h12345678);
    // x0 load then three loads in a row
    add_load(OP_LW, 32'h70, 32'h0, 5'd0, 32'h80ff7f01);
    add_load(OP_LW, 32'h40, 32'h0, 5'd1, 32'h12345678);
    add_load(OP_LW, 32'h50, 32'h0, 5'd2, 32'hd4c3b2a1);
    add_load(OP_LW, 32'h60, 32'h0, 5'd3, 32'hcafebeef);
  endtask

  // outputs checked on the falling edge
  always @(negedge clk) begin : monitor
    entry_t      e;
    wb_t         exp_wb;
    exc_t        exp_exc;
    logic [31:0] ea;
    if (!rst_n) begin
      if (dsram_cs || dsram_we || dsram_ben != 4'b0000 || exc.valid || wb.valid) begin
        report_fail($sformatf("Outputs were not idle during reset at time %0t", $time));
      end
    end else begin
      if (acc_due.size() != 0 && acc_due[0] == cyc) begin
        e = tbl[acc_idx[0]];
        void'(acc_due.pop_front());
        void'(acc_idx.pop_front());
        ea = e.req.base + e.req.offset;
        if (e.kind == EXP_EXC) begin
          exp_exc = '{valid: 1'b1, cause: e.cause, tval: ea};
          check_exc(exc, exp_exc);
          if (dsram_cs) begin
            report_fail($sformatf("SRAM was accessed by a misaligned request at time %0t",
                                  $time));
          end
        end else begin
          if (exc.valid) begin
            report_fail($sformatf("Aligned access raised an exception at time %0t", $time));
          end
          if (!dsram_cs || dsram_we != e.req.store) begin
            report_fail($sformatf("SRAM access missing or of the wrong kind at time %0t",
                                  $time));
          end
          check_addr(dsram_addr, {ea[31:2], 2'b00});
          if (e.kind == EXP_STORE) begin
            check_store(dsram_ben, dsram_wdata, e.ben, e.val);
          end
        end
      end else if (dsram_cs || exc.valid) begin
        report_fail($sformatf("SRAM access or exception with no request at time %0t", $time));
      end
      if (wb_due.size() != 0 && wb_due[0] == cyc) begin
        void'(wb_due.pop_front());
        exp_wb = wb_exp.pop_front();
        check_wb(wb, exp_wb);
      end else if (wb.valid) begin
        report_fail($sformatf("Writeback appeared with no load behind it at time %0t", $time));
      end
      if (req.valid) begin
        e = tbl[cur_idx];
        acc_due.push_back(cyc + 1);
        acc_idx.push_back(cur_idx);
        if (e.kind == EXP_WB) begin
          exp_wb = '{valid: 1'b1, rd: e.req.rd, data: e.val};
          wb_due.push_back(cyc + 3);
          wb_exp.push_back(exp_wb);
        end
      end
    end
  end

  initial begin
    wait (tbl_len > 0);
    #((tbl_len + 10) * 10);
    report_fail($sformatf("Watchdog expired at time %0t before the test finished", $time));
  end

  initial begin
    err_cnt = 0;
    cur_idx = 0;
    rst_n   = 1'b0;
    req     = '0;
    build_table();
    tbl_len = tbl.size();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < tbl_len; i++) begin
      @(posedge clk);
      req     <= tbl[i].req;
      cur_idx <= i;
    end
    @(posedge clk);
    req <= '0;
    while (acc_due.size() != 0 || wb_due.size() != 0) begin
      @(posedge clk);
    end
    // a couple of quiet cycles to catch stray writebacks
    repeat (2) @(posedge clk);
    if (err_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "checks reported mismatches");
    end
  end

endmodule
